// ==== Bender.yml ====
package:
  name: alu_feedback_path

dependencies: {}

sources:
  # Packages first, thread_pkg is used by alu_word_pkg
  - src/thread_pkg.sv
  - src/alu_word_pkg.sv
  - src/result_input_stage.sv
  - src/s_register_file.sv
  - src/r_flag_stage.sv
  - src/feedback_output_stage.sv
  - src/alu_feedback_path.sv
  - target: test
    files:
      - test/alu_feedback_path_tb.sv

// ==== alu_feedback_path.f ====
src/thread_pkg.sv
src/alu_word_pkg.sv
src/result_input_stage.sv
src/s_register_file.sv
src/r_flag_stage.sv
src/feedback_output_stage.sv
src/alu_feedback_path.sv
test/alu_feedback_path_tb.sv

// ==== src/alu_feedback_path.sv ====
// ALU result feedback path, top level
// Input stage, S register file and R flag stage in parallel, output stage

`default_nettype none

module alu_feedback_path (
    input  logic                      clock,
    input  logic                      rst_n,
    input  alu_word_pkg::alu_result_t result,
    output alu_word_pkg::feedback_t   feedback
);

    // ------------------------------
    // Stage 1 signals
    // ------------------------------

    alu_word_pkg::alu_result_t stage1;
    logic                      s_wren;

    // ------------------------------
    // Stage 0 signals
    // ------------------------------

    alu_word_pkg::word_t s_word;
    thread_pkg::thread_t s_thread;
    alu_word_pkg::word_t r_word;
    logic                zero;
    logic                negative;

    // Two cycles, inputs to stage 1
    result_input_stage u_input (
        .clock    (clock),
        .rst_n    (rst_n),
        .result   (result),
        .stage1   (stage1),
        .s_wren   (s_wren)
    );

    // S path, rb written per thread
    s_register_file u_s_file (
        .clock      (clock),
        .rst_n      (rst_n),
        .s_wren     (s_wren),
        .write_data (stage1.rb),
        .s_word     (s_word),
        .s_thread   (s_thread)
    );

    // R path, ra with flags
    r_flag_stage u_r_flags (
        .clock    (clock),
        .rst_n    (rst_n),
        .ra       (stage1.ra),
        .r_word   (r_word),
        .zero     (zero),
        .negative (negative)
    );

    // Last register, four cycles in total
    feedback_output_stage u_output (
        .clock    (clock),
        .rst_n    (rst_n),
        .r_word   (r_word),
        .zero     (zero),
        .negative (negative),
        .s_word   (s_word),
        .s_thread (s_thread),
        .feedback (feedback)
    );

endmodule : alu_feedback_path

`default_nettype wire

// ==== src/alu_word_pkg.sv ====
// ALU datapath definitions
// Word and address types, S write address, result and feedback structs

`default_nettype none

package alu_word_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // One ALU word
    localparam int WORD_WIDTH = 36;

    // Data write address (db)
    localparam int ADDR_WIDTH = 10;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ------------------------------
    // Memory map
    // ------------------------------

    // Single data address that lands in the S register
    // No range decode, one location only
    localparam addr_t S_WRITE_ADDR = 10'h3E8;

    // ------------------------------
    // Structs
    // ------------------------------

    // One item from the ALU, one per cycle
    typedef struct packed {
        // Instruction not stalled on I/O
        logic  io_ready;
        // Instruction annulled
        logic  cancel;
        // Write address of rb
        addr_t db;
        // First result, becomes R
        word_t ra;
        // Second result, candidate for S
        word_t rb;
    } alu_result_t;

    // Returned to the forward path four cycles later
    typedef struct packed {
        // Previous ra
        word_t             r;
        // R is all zeros
        logic              r_zero;
        // Sign bit of R
        logic              r_negative;
        // Stored S of this thread, before this item's write
        word_t             s;
        // Thread owning this item
        thread_pkg::thread_t thread;
    } feedback_t;

endpackage : alu_word_pkg

`default_nettype wire

// ==== src/feedback_output_stage.sv ====
// Feedback output stage
// Packs R, flags, S and thread into one struct and registers it

`default_nettype none

module feedback_output_stage (
    input  logic                      clock,
    input  logic                      rst_n,
    input  alu_word_pkg::word_t       r_word,
    input  logic                      zero,
    input  logic                      negative,
    input  alu_word_pkg::word_t       s_word,
    input  thread_pkg::thread_t       s_thread,
    output alu_word_pkg::feedback_t   feedback
);

    // ------------------------------
    // Merge
    // ------------------------------

    // Both parts are one cycle deep, no alignment needed
    alu_word_pkg::feedback_t merged;

    always_comb begin
        merged.r          = r_word;
        merged.r_zero     = zero;
        merged.r_negative = negative;
        merged.s          = s_word;
        // Thread counter lives with S storage
        merged.thread     = s_thread;
    end

    // ------------------------------
    // Output register
    // ------------------------------

    // Sync point toward the forward path
    // All fields zero while in reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            feedback <= '0;
        end else begin
            feedback <= merged;
        end
    end

endmodule : feedback_output_stage

`default_nettype wire

// ==== src/r_flag_stage.sv ====
// R flag stage
// Zero and negative flags of ra, registered together with R

`default_nettype none

module r_flag_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  alu_word_pkg::word_t ra,
    output alu_word_pkg::word_t r_word,
    output logic                zero,
    output logic                negative
);

    // ------------------------------
    // Flag logic
    // ------------------------------

    logic zero_raw;
    logic negative_raw;

    always_comb begin
        // Reduction over every bit
        zero_raw     = ~|ra;
        // Two's complement sign
        negative_raw = ra[alu_word_pkg::WORD_WIDTH-1];
    end

    // ------------------------------
    // Output register
    // ------------------------------

    // R and its flags leave in the same cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            r_word   <= '0;
            zero     <= 1'b0;
            negative <= 1'b0;
        end else begin
            r_word   <= ra;
            zero     <= zero_raw;
            negative <= negative_raw;
        end
    end

endmodule : r_flag_stage

`default_nettype wire

// ==== src/result_input_stage.sv ====
// Input register pair for the ALU results
// S write enable decode from strobes and db

`default_nettype none

module result_input_stage (
    input  logic                      clock,
    input  logic                      rst_n,
    input  alu_word_pkg::alu_result_t result,
    output alu_word_pkg::alu_result_t stage1,
    output logic                      s_wren
);

    // ------------------------------
    // First input register
    // ------------------------------

    // Item as captured from the ALU
    alu_word_pkg::alu_result_t stage2;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // io_ready low here blocks any S write
            stage2 <= '0;
        end else begin
            stage2 <= result;
        end
    end

    // ------------------------------
    // Write decision
    // ------------------------------

    // Real instruction, neither cancelled nor waiting on I/O
    logic not_nop;
    // db hits the S location
    logic s_hit;
    logic s_wren_next;

    always_comb begin
        not_nop     = stage2.io_ready && !stage2.cancel;
        s_hit       = (stage2.db == alu_word_pkg::S_WRITE_ADDR);
        s_wren_next = not_nop && s_hit;
    end

    // ------------------------------
    // Second input register
    // ------------------------------

    // Enable travels with its item so both arrive in stage 1
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stage1 <= '0;
            s_wren <= 1'b0;
        end else begin
            stage1 <= stage2;
            s_wren <= s_wren_next;
        end
    end

endmodule : result_input_stage

`default_nettype wire

// ==== src/s_register_file.sv ====
// Per-thread S storage
// Round-robin thread counter, write port, read port one thread ahead

`default_nettype none

module s_register_file (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        s_wren,
    input  alu_word_pkg::word_t         write_data,
    output alu_word_pkg::word_t         s_word,
    output thread_pkg::thread_t         s_thread
);

    // ------------------------------
    // Thread counter
    // ------------------------------

    // Reset values chosen so that stage 1 of the first item after reset
    // sees thread 0 two cycles later
    localparam thread_pkg::thread_t CURRENT_INIT =
        thread_pkg::THREAD_WIDTH'(thread_pkg::THREAD_COUNT - 2);
    localparam thread_pkg::thread_t NEXT_INIT =
        thread_pkg::THREAD_WIDTH'(thread_pkg::THREAD_COUNT - 1);
    localparam thread_pkg::thread_t LAST_THREAD =
        thread_pkg::THREAD_WIDTH'(thread_pkg::THREAD_COUNT - 1);

    // Thread of the item now in stage 1
    thread_pkg::thread_t current_thread;
    // Thread of the item entering stage 1 next cycle
    thread_pkg::thread_t next_thread;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            current_thread <= CURRENT_INIT;
            next_thread    <= NEXT_INIT;
        end else begin
            // Wrap explicitly, count need not be a power of two
            if (current_thread == LAST_THREAD) begin
                current_thread <= '0;
            end else begin
                current_thread <= current_thread + 1'b1;
            end
            if (next_thread == LAST_THREAD) begin
                next_thread <= '0;
            end else begin
                next_thread <= next_thread + 1'b1;
            end
        end
    end

    // ------------------------------
    // Storage and write port
    // ------------------------------

    // One S word per thread
    alu_word_pkg::word_t s_mem [thread_pkg::THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // S reads zero until first written
            for (int i = 0; i < thread_pkg::THREAD_COUNT; i++) begin
                s_mem[i] <= '0;
            end
        end else if (s_wren) begin
            s_mem[current_thread] <= write_data;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Prefetch of the next thread's entry
    // Lands in step with that thread's item reaching stage 1
    // Its own write comes one edge later, so this is old data
    alu_word_pkg::word_t read_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= s_mem[next_thread];
        end
    end

    // Output register, same depth as the R flag stage
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s_word   <= '0;
            s_thread <= '0;
        end else begin
            s_word   <= read_data;
            s_thread <= current_thread;
        end
    end

endmodule : s_register_file

`default_nettype wire

// ==== src/thread_pkg.sv ====
// Barrel scheduler definitions
// Thread count and thread number type

`default_nettype none

package thread_pkg;

    // ------------------------------
    // Threading
    // ------------------------------

    // Number of hardware threads, issued round-robin
    localparam int THREAD_COUNT = 8;

    // Enough bits to name every thread
    localparam int THREAD_WIDTH = 3;

    // One thread number
    typedef logic [THREAD_WIDTH-1:0] thread_t;

endpackage : thread_pkg

`default_nettype wire

// ==== test/alu_feedback_path_tb.sv ====
// Testbench for the ALU result feedback path
// Xorshift stimulus, reference model of R, flags and S, compare tasks, watchdog

`default_nettype none

module alu_feedback_path_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------
    // Sizes and timing
    // ------------------------------

    localparam int CLOCK_PERIOD   = 4;
    localparam int RESET_CYCLES   = 4;
    // Cycles from issue to feedback
    localparam int LATENCY        = 4;
    localparam int TEST_COUNT     = 6;
    localparam int RESET_ITEMS    = 16;
    localparam int R_ITEMS        = 64;
    localparam int FLAG_ITEMS     = 64;
    localparam int WRITE_ITEMS    = 64;
    localparam int SUPPRESS_ITEMS = 48;
    localparam int OLD_DATA_ITEMS = 32;
    localparam int REAL_ITEMS     = RESET_ITEMS + R_ITEMS + FLAG_ITEMS + WRITE_ITEMS
                                    + SUPPRESS_ITEMS + OLD_DATA_ITEMS;
    // Reset, all items, then the pipeline flush
    localparam int TOTAL_CYCLES   = RESET_CYCLES + REAL_ITEMS + 2 * LATENCY;

    logic                      clock;
    logic                      rst_n;
    alu_word_pkg::alu_result_t result;
    alu_word_pkg::feedback_t   feedback;

    alu_feedback_path dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .result   (result),
        .feedback (feedback)
    );

    // ------------------------------
    // Testbench state
    // ------------------------------

    logic [31:0]               rng_state;
    // Issued items waiting for their feedback, with their test number
    alu_word_pkg::alu_result_t issue_queue[$];
    int                        test_queue[$];
    // S as the reference model sees it, one entry per thread
    alu_word_pkg::word_t       model_s [thread_pkg::THREAD_COUNT];
    int                        issued_count;
    int                        checked_count;
    int                        check_total [TEST_COUNT];
    int                        error_total [TEST_COUNT];
    // Issue index of each test's final item
    int                        last_index [TEST_COUNT];
    string                     test_name [TEST_COUNT];

    initial begin : clock_generator
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // ------------------------------
    // Random stimulus
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic alu_word_pkg::word_t random_word();
        logic [31:0] high;
        logic [31:0] low;
        high = next_random();
        low  = next_random();
        return {high[3:0], low};
    endfunction

    // Random strobes, db and both words
    function automatic alu_word_pkg::alu_result_t random_item();
        alu_word_pkg::alu_result_t item;
        logic [31:0]               bits;
        bits          = next_random();
        item.io_ready = bits[0];
        item.cancel   = bits[1];
        item.db       = bits[31:22];
        item.ra       = random_word();
        item.rb       = random_word();
        return item;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    // Called in issue order; S is returned as it was before this item
    function automatic alu_word_pkg::feedback_t reference_feedback(
        input alu_word_pkg::alu_result_t item,
        input int                        index
    );
        alu_word_pkg::feedback_t expected;
        thread_pkg::thread_t     owner;
        owner               = thread_pkg::thread_t'(index % thread_pkg::THREAD_COUNT);
        expected.r          = item.ra;
        expected.r_zero     = (item.ra == '0);
        expected.r_negative = ($signed(item.ra) < 0);
        expected.s          = model_s[owner];
        expected.thread     = owner;
        // Write only for a live instruction aimed at the S address
        if (item.io_ready && !item.cancel && item.db == alu_word_pkg::S_WRITE_ADDR) begin
            model_s[owner] = item.rb;
        end
        return expected;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_feedback(
        input alu_word_pkg::feedback_t actual,
        input alu_word_pkg::feedback_t expected,
        input int                      test_id,
        input int                      index
    );
        check_total[test_id]++;
        if (actual.r !== expected.r) begin
            $display("ERROR feedback.r item %0d: got %h, expected %h",
                     index, actual.r, expected.r);
            error_total[test_id]++;
        end
        if (actual.r_zero !== expected.r_zero) begin
            $display("ERROR feedback.r_zero item %0d: got %h, expected %h",
                     index, actual.r_zero, expected.r_zero);
            error_total[test_id]++;
        end
        if (actual.r_negative !== expected.r_negative) begin
            $display("ERROR feedback.r_negative item %0d: got %h, expected %h",
                     index, actual.r_negative, expected.r_negative);
            error_total[test_id]++;
        end
        if (actual.thread !== expected.thread) begin
            $display("ERROR feedback.thread item %0d: got %h, expected %h",
                     index, actual.thread, expected.thread);
            error_total[test_id]++;
        end
    endtask

    task automatic check_s(
        input alu_word_pkg::word_t actual,
        input alu_word_pkg::word_t expected,
        input int                  test_id,
        input int                  index
    );
        check_total[test_id]++;
        if (actual !== expected) begin
            $display("ERROR feedback.s item %0d: got %h, expected %h", index, actual, expected);
            error_total[test_id]++;
        end
    endtask

    // Whole struct must be zero while rst_n is low
    task automatic check_reset_zero();
        check_total[0]++;
        if (feedback !== '0) begin
            $display("ERROR feedback during reset: got %h, expected 0", feedback);
            error_total[0]++;
        end
    endtask

    task automatic report_test(input int test_id);
        string verdict;
        verdict = (error_total[test_id] == 0) ? "ok" : "failed";
        $display("test %0d %s: %0d checks, %0d errors, %s", test_id, test_name[test_id],
                 check_total[test_id], error_total[test_id], verdict);
    endtask

    // Drive one item, then move to the next drive slot
    task automatic issue_item(input alu_word_pkg::alu_result_t item, input int test_id);
        result = item;
        issue_queue.push_back(item);
        test_queue.push_back(test_id);
        issued_count++;
        @(posedge clock);
        #0.5;
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------

    // Sampled 1 ns after the edge, clear of the 0.5 ns drive slot
    initial begin : compare_process
        alu_word_pkg::alu_result_t item;
        alu_word_pkg::feedback_t   expected;
        int                        test_id;
        forever begin
            @(posedge clock);
            #1;
            if (issue_queue.size() > LATENCY) begin
                item     = issue_queue.pop_front();
                test_id  = test_queue.pop_front();
                expected = reference_feedback(item, checked_count);
                check_feedback(feedback, expected, test_id, checked_count);
                check_s(feedback.s, expected.s, test_id, checked_count);
                if (checked_count == last_index[test_id]) begin
                    report_test(test_id);
                end
                checked_count++;
            end
        end
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + 50) * CLOCK_PERIOD);
        $display("Watchdog timeout: not all feedback items were checked in time");
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin : main_sequence
        alu_word_pkg::alu_result_t item;
        int                        total_checks;
        int                        total_errors;
        int                        failed_tests;
        rst_n         = 1'b0;
        result        = '0;
        rng_state     = 32'h58f7_a90c;
        issued_count  = 0;
        checked_count = 0;
        for (int t = 0; t < TEST_COUNT; t++) begin
            check_total[t] = 0;
            error_total[t] = 0;
            last_index[t]  = -1;
        end
        for (int i = 0; i < thread_pkg::THREAD_COUNT; i++) begin
            model_s[i] = '0;
        end
        test_name[0] = "reset_state";
        test_name[1] = "r_and_thread";
        test_name[2] = "flags";
        test_name[3] = "s_write";
        test_name[4] = "suppressed_writes";
        test_name[5] = "old_data";

        // Feedback all zero on each reset edge
        repeat (RESET_CYCLES) begin
            @(posedge clock);
            #0.5;
            check_reset_zero();
        end
        rst_n = 1'b1;

        // No writes yet, S reads zero on every thread
        for (int i = 0; i < RESET_ITEMS; i++) begin
            item = random_item();
            if (item.db == alu_word_pkg::S_WRITE_ADDR) begin
                item.db = item.db ^ alu_word_pkg::addr_t'(1);
            end
            issue_item(item, 0);
        end
        last_index[0] = issued_count - 1;

        for (int i = 0; i < R_ITEMS; i++) begin
            issue_item(random_item(), 1);
        end
        last_index[1] = issued_count - 1;

        // Zero words, sign bit only, sign set and sign clear
        for (int i = 0; i < FLAG_ITEMS; i++) begin
            item = random_item();
            case (i % 5)
                0: item.ra = '0;
                1: item.ra = alu_word_pkg::word_t'(1) << (alu_word_pkg::WORD_WIDTH - 1);
                2: item.ra[alu_word_pkg::WORD_WIDTH-1] = 1'b1;
                3: item.ra[alu_word_pkg::WORD_WIDTH-1] = 1'b0;
                default: item.ra = random_word();
            endcase
            issue_item(item, 2);
        end
        last_index[2] = issued_count - 1;

        // Every third item misses S, so threads hold values for varying times
        for (int i = 0; i < WRITE_ITEMS; i++) begin
            item          = random_item();
            item.io_ready = 1'b1;
            item.cancel   = 1'b0;
            item.db       = alu_word_pkg::S_WRITE_ADDR;
            if (i % 3 == 0) begin
                item.db = alu_word_pkg::S_WRITE_ADDR ^ alu_word_pkg::addr_t'(1);
            end
            issue_item(item, 3);
        end
        last_index[3] = issued_count - 1;

        // Cancelled, stalled on I/O, wrong db, and both strobes off
        for (int i = 0; i < SUPPRESS_ITEMS; i++) begin
            item          = random_item();
            item.io_ready = 1'b1;
            item.cancel   = 1'b0;
            item.db       = alu_word_pkg::S_WRITE_ADDR;
            case (i % 4)
                0: item.cancel = 1'b1;
                1: item.io_ready = 1'b0;
                2: item.db = alu_word_pkg::S_WRITE_ADDR ^ alu_word_pkg::addr_t'(2);
                default: begin
                    item.io_ready = 1'b0;
                    item.cancel   = 1'b1;
                end
            endcase
            issue_item(item, 4);
        end
        last_index[4] = issued_count - 1;

        // Each item writes a tagged word; its own feedback still shows the old S
        for (int i = 0; i < OLD_DATA_ITEMS; i++) begin
            item          = random_item();
            item.io_ready = 1'b1;
            item.cancel   = 1'b0;
            item.db       = alu_word_pkg::S_WRITE_ADDR;
            item.rb[alu_word_pkg::WORD_WIDTH-1 -: 8] = 8'(i);
            issue_item(item, 5);
        end
        last_index[5] = issued_count - 1;

        // Idle items push the last real ones out of the pipeline
        for (int i = 0; i < LATENCY; i++) begin
            issue_item('0, TEST_COUNT - 1);
        end
        wait (checked_count == REAL_ITEMS);

        total_checks = 0;
        total_errors = 0;
        failed_tests = 0;
        for (int t = 0; t < TEST_COUNT; t++) begin
            total_checks += check_total[t];
            total_errors += error_total[t];
            if (error_total[t] != 0) begin
                failed_tests++;
            end
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 TEST_COUNT, failed_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : alu_feedback_path_tb

`default_nettype wire
